// File: project.f
rtl/timer_pkg.sv
rtl/bus_ctrl.sv
rtl/machine_timer.sv
rtl/tick_prescaler.sv
rtl/timer_top.sv
testbench/timer_tb.sv

// File: Makefile
# Verilator build and run of the machine-timer testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing -Wall -Wno-fatal
TOP      ?= timer_tb
FILELIST ?= project.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) into $(LOG) and check the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS: see $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/timer_tb.sv
// Testbench with clock, reset, bus handshake, stimulus table and checks
module timer_tb;

    localparam int ACK_EDGES   = 3;                  // Sampling edge plus the 2-cycle ack latency
    localparam int ACK_TIMEOUT = 50;
    localparam int RATE_GAP    = 25;                 // Idle cycles so two reads start 30 cycles apart

    typedef enum logic [2:0] {
        CHK_NONE,
        CHK_RDATA,
        CHK_MTI,
        CHK_MTIME,
        CHK_MARK,
        CHK_RATE
    } chk_t;

    typedef struct packed {
        logic [timer_pkg::ADDR_W-1:0] addr;
        logic [timer_pkg::BE_W-1:0]   be;
        logic [timer_pkg::DATA_W-1:0] wdata;
        logic [7:0]                   gap;           // Idle cycles before the access
        chk_t                         chk;
        logic [timer_pkg::DATA_W-1:0] exp;
    } entry_t;

    logic                         clk;
    logic                         reset_n;
    logic                         req_i;
    timer_pkg::bus_req_t          bus_req;
    logic                         ack_o;
    logic [timer_pkg::DATA_W-1:0] rdata_o;
    logic                         mti_o;
    logic [timer_pkg::DATA_W-1:0] mtime_o;

    entry_t                       stim_q[$];
    logic [31:0]                  lcg_state = 32'h2f44_9309;
    int unsigned                  cycle_cnt = 0;
    int unsigned                  mark_cycle;
    logic [timer_pkg::DATA_W-1:0] mark_val;

    timer_top i_timer_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_i     (req_i),
        .bus_req_i (bus_req),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .mti_o     (mti_o),
        .mtime_o   (mtime_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ************************************************************************
    // Helpers
    // ************************************************************************
    task automatic fail_stop();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand64(output logic [63:0] v);
        lcg_state = lcg_step(lcg_state);
        v[63:32]  = lcg_state;
        lcg_state = lcg_step(lcg_state);
        v[31:0]   = lcg_state;
    endtask

    // Register view after a write; an upper-half access shifts lanes 3..0 up by four bytes
    function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic hi,
                                                input logic [7:0] be, input logic [63:0] data);
        logic [63:0] lane_data;
        logic [7:0]  lane_en;
        logic [63:0] mask;
        lane_data = hi ? (data << 32) : data;
        lane_en   = hi ? (be << 4) : be;
        for (int b = 0; b < 8; b++) begin
            mask[8*b +: 8] = {8{lane_en[b]}};
        end
        return (old & ~mask) | (lane_data & mask);
    endfunction

    function automatic void add_entry(input logic [4:0] addr, input logic [7:0] be,
                                      input logic [63:0] wdata, input logic [7:0] gap,
                                      input chk_t chk, input logic [63:0] exp);
        entry_t e;
        e.addr  = addr;
        e.be    = be;
        e.wdata = wdata;
        e.gap   = gap;
        e.chk   = chk;
        e.exp   = exp;
        stim_q.push_back(e);
    endfunction

    // ************************************************************************
    // Bus access with handshake checks
    // ************************************************************************
    task automatic bus_access(input entry_t e, output logic [63:0] rdata);
        int waited;
        waited = 0;
        assert (!ack_o) else begin
            $display("ack_o was high before a request was issued");
            fail_stop();
        end
        bus_req.addr  = e.addr;
        bus_req.be    = e.be;
        bus_req.wdata = e.wdata;
        req_i         = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack_o && waited < ACK_TIMEOUT);
        if (!ack_o) begin
            $display("Timed out waiting for ack_o to rise after a request");
            fail_stop();
        end
        assert (waited == ACK_EDGES) else begin
            $display("[FAIL] ack_o latency got %h expected %h", waited, ACK_EDGES);
            fail_stop();
        end
        rdata = rdata_o;
        @(negedge clk);                              // Hold the request one extra cycle
        assert (ack_o && (rdata_o == rdata)) else begin
            $display("[FAIL] rdata_o under back-pressure got %h expected %h", rdata_o, rdata);
            fail_stop();
        end
        req_i  = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack_o && waited < ACK_TIMEOUT);
        if (ack_o) begin
            $display("Timed out waiting for ack_o to fall after the request was dropped");
            fail_stop();
        end
    endtask

    task automatic check_entry(input int idx, input entry_t e, input logic [63:0] got,
                               input int unsigned start);
        longint sep;
        longint want;
        longint delta;
        case (e.chk)
            CHK_RDATA: assert (got == e.exp) else begin
                $display("[FAIL] rdata_o got %h expected %h at entry %0d", got, e.exp, idx);
                fail_stop();
            end
            CHK_MTI: assert (mti_o == e.exp[0]) else begin
                $display("[FAIL] mti_o got %h expected %h at entry %0d", mti_o, e.exp[0], idx);
                fail_stop();
            end
            CHK_MTIME: assert (mtime_o == e.exp) else begin
                $display("[FAIL] mtime_o got %h expected %h at entry %0d", mtime_o, e.exp, idx);
                fail_stop();
            end
            CHK_MARK: begin
                mark_val   = got;
                mark_cycle = start;
            end
            CHK_RATE: begin
                sep   = longint'(start - mark_cycle);
                want  = sep / longint'(e.exp);       // Expected ticks for this divider
                delta = longint'(got - mark_val);
                assert ((delta + 1 >= want) && (delta <= want + 1)) else begin
                    $display("[FAIL] mtime delta got %h expected %h +/- 1 at entry %0d",
                             delta, want, idx);
                    fail_stop();
                end
            end
            default: ;
        endcase
    endtask

    // ************************************************************************
    // Stimulus table
    // ************************************************************************
    task automatic build_stimulus();
        logic [63:0] m_val;
        logic [63:0] c_full;
        logic [63:0] d_lo;
        logic [63:0] d_hi;
        logic [63:0] cmp_model;
        logic [63:0] r;
        next_rand64(m_val);
        m_val = {1'b0, m_val[62:0]} | 64'h100;     // Room for the compare values around it
        next_rand64(c_full);
        next_rand64(d_lo);
        next_rand64(d_hi);
        next_rand64(r);
        cmp_model = merge_bytes(c_full, 1'b0, 8'hA5, d_lo);
        cmp_model = merge_bytes(cmp_model, 1'b1, 8'h06, d_hi);
        add_entry(timer_pkg::OFS_PRESCALE, 8'h00, 64'd0, 8'd0, CHK_RDATA, 64'd1);
        add_entry(timer_pkg::OFS_PRESCALE, 8'h03, 64'd0, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIME, 8'hFF, m_val, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'd0, CHK_RDATA, m_val);
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'd5, CHK_RDATA, m_val);
        add_entry(timer_pkg::OFS_MTIME_HI, 8'h00, 64'd0, 8'd0, CHK_RDATA, {32'd0, m_val[63:32]});
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'd0, CHK_MTIME, m_val);
        add_entry(timer_pkg::OFS_MTIMECMP, 8'hFF, c_full, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIMECMP, 8'hA5, d_lo, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIMECMP_HI, 8'h06, d_hi, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIMECMP, 8'h00, 64'd0, 8'd0, CHK_RDATA, cmp_model);
        add_entry(timer_pkg::OFS_MTIMECMP_HI, 8'h00, 64'd0, 8'd0, CHK_RDATA,
                  {32'd0, cmp_model[63:32]});
        add_entry(timer_pkg::OFS_MTIMECMP, 8'hFF, m_val, 8'd0, CHK_MTI, 64'd1);
        add_entry(timer_pkg::OFS_MTIMECMP, 8'hFF, m_val + 64'd1, 8'd0, CHK_MTI, 64'd0);
        add_entry(timer_pkg::OFS_MTIMECMP, 8'hFF, m_val - 64'd5, 8'd0, CHK_MTI, 64'd1);
        add_entry(timer_pkg::OFS_PRESCALE, 8'h03, {48'd0, r[15:0]}, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_PRESCALE, 8'h00, 64'd0, 8'd0, CHK_RDATA, {48'd0, r[15:0]});
        add_entry(5'h14, 8'hFF, c_full, 8'd0, CHK_NONE, 64'd0);
        add_entry(5'h14, 8'h00, 64'd0, 8'd0, CHK_RDATA, 64'd0);
        add_entry(5'h18, 8'h00, 64'd0, 8'd0, CHK_RDATA, 64'd0);
        add_entry(timer_pkg::OFS_PRESCALE, 8'h03, 64'd3, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'd0, CHK_MARK, 64'd0);
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'(RATE_GAP), CHK_RATE, 64'd3);
        add_entry(timer_pkg::OFS_PRESCALE, 8'h03, 64'd1, 8'd0, CHK_NONE, 64'd0);
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'd0, CHK_MARK, 64'd0);
        add_entry(timer_pkg::OFS_MTIME, 8'h00, 64'd0, 8'(RATE_GAP), CHK_RATE, 64'd1);
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************
    initial begin
        entry_t      e;
        logic [63:0] got;
        int unsigned start;
        clk     = 1'b0;
        reset_n = 1'b0;
        req_i   = 1'b0;
        bus_req = '0;
        build_stimulus();
        repeat (2) @(negedge clk);
        assert (!ack_o && !mti_o) else begin
            $display("[FAIL] ack_o %h mti_o %h expected 0 in reset", ack_o, mti_o);
            fail_stop();
        end
        reset_n = 1'b1;
        repeat (4) begin                             // No acknowledge without a request
            @(negedge clk);
            assert (!ack_o) else begin
                $display("ack_o rose while no request was pending");
                fail_stop();
            end
        end
        assert (mti_o) else begin
            $display("[FAIL] mti_o got %h expected 1 after reset", mti_o);
            fail_stop();
        end
        for (int i = 0; i < stim_q.size(); i++) begin
            e = stim_q[i];
            repeat (e.gap) @(negedge clk);
            start = cycle_cnt;
            bus_access(e, got);
            check_entry(i, e, got, start);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: rtl/timer_top.sv
// Top level of the machine-timer peripheral with bus control, timer and prescaler
module timer_top (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          req_i,
    input  timer_pkg::bus_req_t           bus_req_i,
    output logic                          ack_o,
    output logic [timer_pkg::DATA_W-1:0]  rdata_o,
    output logic                          mti_o,
    output logic [timer_pkg::DATA_W-1:0]  mtime_o
);

    logic                         tmr_en;
    logic                         psc_en;
    logic                         tick;
    logic [timer_pkg::DATA_W-1:0] tmr_rdata;
    logic [timer_pkg::DATA_W-1:0] psc_rdata;
    timer_pkg::timer_cmd_t        cmd;

    bus_ctrl i_bus_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_i       (req_i),
        .bus_req_i   (bus_req_i),
        .tmr_rdata_i (tmr_rdata),
        .psc_rdata_i (psc_rdata),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .tmr_en_o    (tmr_en),
        .psc_en_o    (psc_en),
        .cmd_o       (cmd)
    );

    // Address bit 3 stays valid through the strobe because the request is held
    machine_timer i_machine_timer (
        .clk       (clk),
        .reset_n   (reset_n),
        .en_i      (tmr_en),
        .cmd_i     (cmd),
        .sel_cmp_i (bus_req_i.addr[3]),
        .tick_i    (tick),
        .rdata_o   (tmr_rdata),
        .mti_o     (mti_o),
        .mtime_o   (mtime_o)
    );

    tick_prescaler i_tick_prescaler (
        .clk     (clk),
        .reset_n (reset_n),
        .en_i    (psc_en),
        .cmd_i   (cmd),
        .tick_o  (tick),
        .rdata_o (psc_rdata)
    );

endmodule

// File: rtl/tick_prescaler.sv
// Programmable tick divider that paces the mtime counter
module tick_prescaler (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          en_i,
    input  timer_pkg::timer_cmd_t         cmd_i,
    output logic                          tick_o,
    output logic [timer_pkg::DATA_W-1:0]  rdata_o
);

    logic [timer_pkg::PRESCALE_W-1:0] div_q;
    logic [timer_pkg::PRESCALE_W-1:0] cnt_q;
    logic                             wr_en;
    logic                             rd_en;

    assign wr_en = en_i && (cmd_i.be != '0);
    assign rd_en = en_i && (cmd_i.be == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_q  <= timer_pkg::PRESCALE_RESET;
            cnt_q  <= '0;
            tick_o <= 1'b0;
        end
        else if (wr_en) begin
            if (cmd_i.be[0]) div_q[7:0]  <= cmd_i.wdata[7:0];
            if (cmd_i.be[1]) div_q[15:8] <= cmd_i.wdata[15:8];
            cnt_q  <= '0;                            // Restart the period on a new divider
            tick_o <= 1'b0;
        end
        else if (div_q == '0) begin
            tick_o <= 1'b0;                          // Timer stopped, counter frozen
        end
        else if (cnt_q >= div_q - 1'b1) begin
            cnt_q  <= '0;
            tick_o <= 1'b1;
        end
        else begin
            cnt_q  <= cnt_q + 1'b1;
            tick_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_o <= {{(timer_pkg::DATA_W-timer_pkg::PRESCALE_W){1'b0}}, div_q};
        end
    end

endmodule

// File: rtl/machine_timer.sv
// Machine timer with mtime and mtimecmp registers, byte-lane merge, read mux and interrupt
module machine_timer (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          en_i,
    input  timer_pkg::timer_cmd_t         cmd_i,
    input  logic                          sel_cmp_i,  // High selects mtimecmp
    input  logic                          tick_i,
    output logic [timer_pkg::DATA_W-1:0]  rdata_o,
    output logic                          mti_o,
    output logic [timer_pkg::DATA_W-1:0]  mtime_o
);

    logic [timer_pkg::DATA_W-1:0] mtime_q;
    logic [timer_pkg::DATA_W-1:0] mtimecmp_q;
    logic [timer_pkg::BE_W-1:0]   wr_be;
    logic                         wr_en;
    logic                         rd_en;
    timer_pkg::timer_word_u       cur_word;
    timer_pkg::timer_word_u       wr_word;
    timer_pkg::timer_word_u       new_word;

    assign wr_en = en_i && (cmd_i.be != '0);
    assign rd_en = en_i && (cmd_i.be == '0);

    assign cur_word.full = sel_cmp_i ? mtimecmp_q : mtime_q;

    // ************************************************************************
    // Byte-lane merge
    // ************************************************************************
    always_comb begin
        wr_word.full = cmd_i.wdata;
        wr_be        = cmd_i.be;
        if (cmd_i.hi) begin
            // Lanes 3..0 of the bus land on bytes 7..4 of the register
            wr_word.halves.hi = cmd_i.wdata[31:0];
            wr_be             = {cmd_i.be[3:0], 4'b0000};
        end
        for (int i = 0; i < timer_pkg::BE_W; i++) begin
            new_word.full[8*i +: 8] = wr_be[i] ? wr_word.full[8*i +: 8]
                                               : cur_word.full[8*i +: 8];
        end
    end

    // ************************************************************************
    // Counter and compare registers
    // ************************************************************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '0;
        end
        else begin
            if (wr_en && !sel_cmp_i) begin
                mtime_q <= new_word.full;            // Bus write wins over the tick
            end
            else if (tick_i) begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr_en && sel_cmp_i) begin
                mtimecmp_q <= new_word.full;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mti_o <= 1'b0;
        end
        else begin
            mti_o <= (mtime_q >= mtimecmp_q);        // Pending while mtime has reached mtimecmp
        end
    end

    // High-half reads come back zero-extended
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (cmd_i.hi) begin
                rdata_o <= {32'd0, cur_word.halves.hi};
            end
            else begin
                rdata_o <= cur_word.full;
            end
        end
    end

    assign mtime_o = mtime_q;

    // Upper-half accesses come from a 32-bit view and only use lanes 3..0
    a_hi_write_lanes: assert property (@(posedge clk) disable iff (!reset_n)
        (en_i && cmd_i.hi && (cmd_i.be != '0)) |-> (cmd_i.be[7:4] == 4'b0000))
        else $error("Upper-half write with byte enables 7..4 set");

endmodule

// File: rtl/bus_ctrl.sv
// Four-phase req/ack slave FSM with address decode, command strobes and read capture
module bus_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          req_i,
    input  timer_pkg::bus_req_t           bus_req_i,
    input  logic [timer_pkg::DATA_W-1:0]  tmr_rdata_i,
    input  logic [timer_pkg::DATA_W-1:0]  psc_rdata_i,
    output logic                          ack_o,
    output logic [timer_pkg::DATA_W-1:0]  rdata_o,
    output logic                          tmr_en_o,
    output logic                          psc_en_o,
    output timer_pkg::timer_cmd_t         cmd_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_CAPTURE,
        ST_ACK
    } state_t;

    state_t                       state_q;
    logic                         sel_tmr_q;         // Request targets the timer block
    logic                         sel_psc_q;         // Request targets the prescaler
    logic                         hit_tmr;
    logic                         hit_psc;
    logic                         accept;
    logic [timer_pkg::DATA_W-1:0] rdata_sel;
    timer_pkg::timer_cmd_t        cmd_q;

    // ************************************************************************
    // Address decode
    // ************************************************************************
    always_comb begin
        hit_tmr = 1'b0;
        hit_psc = 1'b0;
        case (bus_req_i.addr)
            timer_pkg::OFS_MTIME,
            timer_pkg::OFS_MTIME_HI,
            timer_pkg::OFS_MTIMECMP,
            timer_pkg::OFS_MTIMECMP_HI: hit_tmr = 1'b1;
            timer_pkg::OFS_PRESCALE:    hit_psc = 1'b1;
            default: ;                               // Unmapped offsets hit nothing
        endcase
    end

    // A new request only starts from a fully closed handshake
    assign accept = (state_q == ST_IDLE) && req_i && !ack_o;

    // ************************************************************************
    // Handshake FSM
    // ************************************************************************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= ST_IDLE;
            sel_tmr_q <= 1'b0;
            sel_psc_q <= 1'b0;
            ack_o     <= 1'b0;
        end
        else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q   <= ST_STROBE;
                        sel_tmr_q <= hit_tmr;
                        sel_psc_q <= hit_psc;
                    end
                end
                ST_STROBE: begin
                    state_q <= ST_CAPTURE;           // Datapath registers its result here
                end
                ST_CAPTURE: begin
                    state_q <= ST_ACK;
                    ack_o   <= 1'b1;
                end
                ST_ACK: begin
                    if (!req_i) begin                // Master has seen the acknowledge
                        state_q <= ST_IDLE;
                        ack_o   <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command is latched with the request and held through the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q.hi    <= bus_req_i.addr[2];
            cmd_q.be    <= bus_req_i.be;
            cmd_q.wdata <= bus_req_i.wdata;
        end
    end

    // Writes and unmapped offsets return zero
    always_comb begin
        if (cmd_q.be != '0) begin
            rdata_sel = '0;
        end
        else if (sel_tmr_q) begin
            rdata_sel = tmr_rdata_i;
        end
        else if (sel_psc_q) begin
            rdata_sel = psc_rdata_i;
        end
        else begin
            rdata_sel = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_CAPTURE) begin
            rdata_o <= rdata_sel;                    // Held unchanged while ack is high
        end
    end

    assign tmr_en_o = (state_q == ST_STROBE) && sel_tmr_q;
    assign psc_en_o = (state_q == ST_STROBE) && sel_psc_q;
    assign cmd_o    = cmd_q;

    // ************************************************************************
    // Assertions
    // ************************************************************************
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose without a pending request");

    // The timer decodes address bit 3 straight from the bus during the strobe
    a_req_held_at_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        (tmr_en_o || psc_en_o) |-> (req_i && $stable(bus_req_i)))
        else $error("Request dropped or changed before the command strobe");

endmodule

// File: rtl/timer_pkg.sv
// Address map, widths, bus request and timer command structs, timer word union
package timer_pkg;

    // ************************************************************************
    // Widths
    // ************************************************************************
    localparam int ADDR_W     = 5;                   // Byte offset inside the peripheral
    localparam int DATA_W     = 64;                  // Bus data word
    localparam int BE_W       = 8;                   // One enable per data byte
    localparam int PRESCALE_W = 16;                  // Tick divider width

    // ************************************************************************
    // Register map
    // ************************************************************************
    localparam logic [ADDR_W-1:0] OFS_MTIME       = 5'h00;
    localparam logic [ADDR_W-1:0] OFS_MTIME_HI    = 5'h04;  // Upper word of mtime
    localparam logic [ADDR_W-1:0] OFS_MTIMECMP    = 5'h08;
    localparam logic [ADDR_W-1:0] OFS_MTIMECMP_HI = 5'h0C;  // Upper word of mtimecmp
    localparam logic [ADDR_W-1:0] OFS_PRESCALE    = 5'h10;

    localparam logic [PRESCALE_W-1:0] PRESCALE_RESET = 16'd1;  // Count on every clock

    // Request held stable by the master while req is high
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BE_W-1:0]   be;                       // All zero means a read
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // One-cycle command from the bus controller to a datapath block
    typedef struct packed {
        logic              hi;                       // Access to the upper 32-bit half
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } timer_cmd_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } timer_halves_t;

    // A timer register seen whole or as two 32-bit halves
    typedef union packed {
        logic [DATA_W-1:0] full;
        timer_halves_t     halves;
    } timer_word_u;

endpackage
